/* testbench/alu_unit_input.txt */
// op a b result zero overflow, all hex, one command per line
// op: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 not, 6 eq, 7 lt, 8 gt, others undefined
0 00000005 00000007 0000000c 0 0
0 7fffffff 00000001 80000000 0 1
1 80000000 00000001 7fffffff 0 1
2 ff00ff00 0ff00ff0 0f000f00 0 0
3 aaaaaaaa 55555555 ffffffff 0 0
4 ffffffff 0f0f0f0f f0f0f0f0 0 0
5 12345678 ffffffff edcba987 0 0
6 12345678 12345678 00000001 0 0
7 ffffffff 00000001 00000001 0 0
9 12345678 11111111 00000000 1 0
0 80000000 ffffffff 7fffffff 0 1
0 ffffffff 00000001 00000000 1 0
0 80000000 80000000 00000000 1 1
0 7fffffff 7fffffff fffffffe 0 1
0 12345678 11111111 23456789 0 0
0 fffffffe fffffffd fffffffb 0 0
0 00000000 00000000 00000000 1 0
0 40000000 40000000 80000000 0 1
0 c0000000 c0000000 80000000 0 0
0 0000ffff 00000001 00010000 0 0
0 00000001 ffffffff 00000000 1 0
1 0000000a 00000003 00000007 0 0
1 00000003 0000000a fffffff9 0 0
1 7fffffff ffffffff 80000000 0 1
1 00000000 80000000 80000000 0 1
1 12345678 12345678 00000000 1 0
1 ffffffff ffffffff 00000000 1 0
1 80000000 7fffffff 00000001 0 1
1 fffffff0 00000010 ffffffe0 0 0
1 00000000 00000001 ffffffff 0 0
1 7ffffffe 7fffffff ffffffff 0 0
1 80000000 80000000 00000000 1 0
2 aaaaaaaa 55555555 00000000 1 0
2 ffffffff 12345678 12345678 0 0
2 f0f0f0f0 ffff0000 f0f00000 0 0
3 00000000 00000000 00000000 1 0
3 12340000 00005678 12345678 0 0
3 f0000000 0000000f f000000f 0 0
4 12345678 12345678 00000000 1 0
4 aaaaaaaa 55555555 ffffffff 0 0
4 80000001 00000001 80000000 0 0
5 00000000 12345678 ffffffff 0 0
5 ffffffff 00000000 00000000 1 0
5 0f0f0f0f 00000000 f0f0f0f0 0 0
6 12345678 12345679 00000000 1 0
6 80000000 80000000 00000001 0 0
6 00000000 ffffffff 00000000 1 0
7 00000001 ffffffff 00000000 1 0
7 80000000 7fffffff 00000001 0 0
7 00000005 00000005 00000000 1 0
7 fffffffe ffffffff 00000001 0 0
8 7fffffff 80000000 00000001 0 0
8 ffffffff 00000000 00000000 1 0
8 00000010 0000000f 00000001 0 0
8 80000000 80000000 00000000 1 0
8 00000000 ffffffff 00000001 0 0
8 80000000 7fffffff 00000000 1 0
f ffffffff ffffffff 00000000 1 0
c 7fffffff 00000001 00000000 1 0

/* filelist.f */
hw/alu_pkg.sv
hw/alu_fifo.sv
hw/alu_core.sv
hw/alu_unit_top.sv
testbench/alu_unit_props.sv
testbench/alu_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ALU unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert \
    --top-module alu_unit_tb \
    -f filelist.f \
    -o alu_unit_sim

# The pipeline status is that of tee, the log decides the outcome
./obj_dir/alu_unit_sim 2>&1 | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail, see sim.log"
    exit 1
fi

/* testbench/alu_unit_tb.sv */
`default_nettype none

module alu_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic              clk = 1'b0;
    logic              rst;
    logic              cmd_push;
    alu_pkg::alu_cmd_t cmd;
    logic              cmd_full;
    logic              res_pop;
    alu_pkg::alu_res_t res_head;
    logic              res_empty;

    alu_pkg::alu_cmd_t cmd_a[$];   // Commands in file order
    alu_pkg::alu_res_t exp_a[$];   // Expected results, same order
    int                pend_q[$];  // Entries pushed and not yet popped
    int                next_idx = 0;
    logic [31:0]       lfsr     = 32'hafaa_d588;
    int                cycles   = 0;
    int                limit    = 0;  // Set once the file is loaded

    alu_unit_top dut (
        .clk       (clk),
        .rst       (rst),
        .cmd_push  (cmd_push),
        .cmd       (cmd),
        .cmd_full  (cmd_full),
        .res_pop   (res_pop),
        .res_head  (res_head),
        .res_empty (res_empty)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles with results still outstanding", cycles);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    // Right-shifting Galois form
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic logic next_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    task automatic check(input string test, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("error %s expected %0h actual %0h", test, expected, actual);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic read_entries();
        int                             fd;
        int                             n;
        string                          line;
        logic [3:0]                     op;
        logic [alu_pkg::data_width-1:0] a;
        logic [alu_pkg::data_width-1:0] b;
        logic [alu_pkg::data_width-1:0] r;
        logic                           z;
        logic                           o;
        alu_pkg::alu_cmd_t              c;
        alu_pkg::alu_res_t              e;
        fd = $fopen("testbench/alu_unit_input.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/alu_unit_input.txt");
            $display("Testbench failed");
            $fatal(1, "missing stimulus file");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() >= 2 && line.substr(0, 1) == "//") begin
                continue;  // Column notes
            end
            n = $sscanf(line, "%h %h %h %h %h %h", op, a, b, r, z, o);
            if (n == 6) begin
                c.op       = alu_pkg::alu_op_e'(op);
                c.a        = a;
                c.b        = b;
                e.result   = r;
                e.zero     = z;
                e.overflow = o;
                cmd_a.push_back(c);
                exp_a.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // Advance to the next falling edge with strobes cleared
    task automatic wait_cycle();
        @(posedge clk);
        @(negedge clk);
        cmd_push = 1'b0;
        res_pop  = 1'b0;
    endtask

    task automatic issue_push();
        cmd      = cmd_a[next_idx];
        cmd_push = 1'b1;
        pend_q.push_back(next_idx);
        next_idx++;
    endtask

    // Head is stable here, the pop takes effect at the next rising edge
    task automatic pop_and_check(input string phase);
        int    idx;
        string name;
        if (pend_q.size() == 0) begin
            $display("a result came out with no command outstanding");
            $display("Testbench failed");
            $fatal(1, "unexpected result");
        end
        idx  = pend_q.pop_front();
        name = $sformatf("%s entry %0d", phase, idx);
        check({name, " result"}, 64'(exp_a[idx].result), 64'(res_head.result));
        check({name, " zero"}, 64'(exp_a[idx].zero), 64'(res_head.zero));
        check({name, " overflow"}, 64'(exp_a[idx].overflow), 64'(res_head.overflow));
        res_pop = 1'b1;
    endtask

    initial begin
        int   edges;
        int   pushes;
        logic want_push;
        logic want_pop;
        rst      = 1'b1;
        cmd_push = 1'b0;
        cmd      = '0;
        res_pop  = 1'b0;
        read_entries();
        if (cmd_a.size() < alu_pkg::cmd_depth + alu_pkg::res_depth + 1) begin
            $display("stimulus file holds too few entries for the tests");
            $display("Testbench failed");
            $fatal(1, "short stimulus file");
        end
        limit = (cmd_a.size() + 10) * 8;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check("reset res_empty", 64'(1'b1), 64'(res_empty));
        check("reset cmd_full", 64'(1'b0), 64'(cmd_full));

        // Idle unit, the push edge counts as edge 1
        issue_push();
        wait_cycle();
        edges = 1;
        while (res_empty && edges < 8) begin
            wait_cycle();
            edges++;
        end
        check("latency edges", 64'(3), 64'(edges));
        pop_and_check("latency");
        wait_cycle();

        // Consumer stalled, push until the unit refuses
        pushes = 0;
        while (!cmd_full && next_idx < cmd_a.size() &&
               pushes < alu_pkg::cmd_depth + alu_pkg::res_depth + 2) begin
            issue_push();
            pushes++;
            wait_cycle();
        end
        check("back_pressure accepted pushes",
              64'(alu_pkg::cmd_depth + alu_pkg::res_depth), 64'(pushes));
        while (pend_q.size() > 0) begin
            if (!res_empty) begin
                pop_and_check("back_pressure");
            end
            wait_cycle();
        end

        // Remaining entries with random gaps on both sides
        while (next_idx < cmd_a.size() || pend_q.size() > 0) begin
            want_push = next_bit();
            want_pop  = next_bit();
            if (want_push && !cmd_full && next_idx < cmd_a.size()) begin
                issue_push();
            end
            if (want_pop && !res_empty) begin
                pop_and_check("random");
            end
            wait_cycle();
        end
        check("final res_empty", 64'(1'b1), 64'(res_empty));
        check("final cmd_full", 64'(1'b0), 64'(cmd_full));

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/alu_unit_props.sv */
`default_nettype none

module alu_unit_props #(
    parameter int depth     = 4,
    parameter bit same_fifo = 1'b1  // Full and empty belong to one FIFO
) (
    input logic                       clk,
    input logic                       rst,
    input logic                       push,
    input logic                       pop,
    input logic                       empty,
    input logic                       full,
    input logic [$clog2(depth+1)-1:0] count
);
    timeunit 1ns;
    timeprecision 1ps;

    pop_needs_data: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("pop while empty");

    count_in_range: assert property (@(posedge clk) disable iff (rst) int'(count) <= depth)
        else $error("occupancy above depth %0d", depth);

    // Covers the ALU stage pushing into a full result FIFO
    push_needs_room: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("push while full");

    generate
        if (same_fifo) begin : g_levels
            levels_exclusive: assert property (@(posedge clk) disable iff (rst)
                !(full && empty))
                else $error("full and empty high together");
        end
    endgenerate

endmodule

// Both buffer instances
bind alu_fifo alu_unit_props #(
    .depth     (depth),
    .same_fifo (1'b1)
) fifo_props (
    .clk   (clk),
    .rst   (rst),
    .push  (push),
    .pop   (pop),
    .empty (empty),
    .full  (full),
    .count (count)
);

// ALU stage, command side pop and result side push
bind alu_core alu_unit_props #(
    .depth     (alu_pkg::res_depth),
    .same_fifo (1'b0)
) core_props (
    .clk   (clk),
    .rst   (rst),
    .push  (res_push),
    .pop   (cmd_pop),
    .empty (cmd_empty),
    .full  (int'(res_count) == alu_pkg::res_depth),
    .count (res_count)
);

`default_nettype wire

/* hw/alu_unit_top.sv */
`default_nettype none

module alu_unit_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_push,
    input  alu_pkg::alu_cmd_t cmd,
    output logic              cmd_full,
    input  logic              res_pop,
    output alu_pkg::alu_res_t res_head,
    output logic              res_empty
);

    alu_pkg::alu_cmd_t                 cmd_head;
    logic                              cmd_empty;
    logic                              cmd_pop;
    logic                              res_push;
    alu_pkg::alu_res_t                 res_in;
    logic [alu_pkg::res_cnt_width-1:0] res_count;

    // Commands from the producer
    alu_fifo #(
        .payload_t (alu_pkg::alu_cmd_t),
        .depth     (alu_pkg::cmd_depth)
    ) cmd_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (cmd_push),
        .push_data (cmd),
        .pop       (cmd_pop),
        .head      (cmd_head),
        .empty     (cmd_empty),
        .full      (cmd_full),
        .count     ()
    );

    alu_core core (
        .clk       (clk),
        .rst       (rst),
        .cmd_head  (cmd_head),
        .cmd_empty (cmd_empty),
        .cmd_pop   (cmd_pop),
        .res_count (res_count),
        .res_push  (res_push),
        .res_in    (res_in)
    );

    // Results for the consumer, the count feeds back to the ALU stage
    alu_fifo #(
        .payload_t (alu_pkg::alu_res_t),
        .depth     (alu_pkg::res_depth)
    ) res_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (res_push),
        .push_data (res_in),
        .pop       (res_pop),
        .head      (res_head),
        .empty     (res_empty),
        .full      (),
        .count     (res_count)
    );

endmodule

`default_nettype wire

/* hw/alu_core.sv */
`default_nettype none

module alu_core (
    input  logic                              clk,
    input  logic                              rst,
    input  alu_pkg::alu_cmd_t                 cmd_head,
    input  logic                              cmd_empty,
    output logic                              cmd_pop,
    input  logic [alu_pkg::res_cnt_width-1:0] res_count,
    output logic                              res_push,
    output alu_pkg::alu_res_t                 res_in
);

    logic                           pending;     // Stage holds a result not yet pushed
    alu_pkg::alu_res_t              res_q;
    logic [alu_pkg::data_width-1:0] sum;
    logic [alu_pkg::data_width-1:0] diff;
    logic [alu_pkg::data_width-1:0] alu_result;
    logic                           alu_zero;
    logic                           alu_ovf;
    logic                           sign_a;
    logic                           sign_b;
    logic                           room;

    // Count the held result too, so the result FIFO cannot overflow
    assign room    = (int'(res_count) + int'(pending)) < alu_pkg::res_depth;
    assign cmd_pop = !cmd_empty && room;

    assign sign_a = cmd_head.a[alu_pkg::data_width-1];
    assign sign_b = cmd_head.b[alu_pkg::data_width-1];
    assign sum    = cmd_head.a + cmd_head.b;
    assign diff   = cmd_head.a - cmd_head.b;

    // Evaluate the command at the head of the buffer
    always_comb begin
        alu_ovf = 1'b0;
        case (cmd_head.op)
            alu_pkg::op_add: begin
                alu_result = sum;
                // Like signs in, other sign out
                alu_ovf    = (sign_a == sign_b) && (sign_a != sum[alu_pkg::data_width-1]);
            end
            alu_pkg::op_sub: begin
                alu_result = diff;
                alu_ovf    = (sign_a != sign_b) && (sign_a != diff[alu_pkg::data_width-1]);
            end
            alu_pkg::op_and: begin
                alu_result = cmd_head.a & cmd_head.b;
            end
            alu_pkg::op_or: begin
                alu_result = cmd_head.a | cmd_head.b;
            end
            alu_pkg::op_xor: begin
                alu_result = cmd_head.a ^ cmd_head.b;
            end
            alu_pkg::op_not: begin
                alu_result = ~cmd_head.a;
            end
            alu_pkg::op_eq: begin
                alu_result = (cmd_head.a == cmd_head.b) ? 32'd1 : 32'd0;
            end
            alu_pkg::op_lt: begin
                alu_result = ($signed(cmd_head.a) < $signed(cmd_head.b)) ? 32'd1 : 32'd0;
            end
            alu_pkg::op_gt: begin
                alu_result = ($signed(cmd_head.a) > $signed(cmd_head.b)) ? 32'd1 : 32'd0;
            end
            default: begin
                alu_result = '0;  // Unknown opcode, zero flag follows
            end
        endcase
        alu_zero = (alu_result == '0);
    end

    // Result register, loaded on every pop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
            res_q   <= '0;
        end else begin
            // The held result always leaves on the next edge, room was checked at pop
            pending <= cmd_pop;
            if (cmd_pop) begin
                res_q.result   <= alu_result;
                res_q.zero     <= alu_zero;
                res_q.overflow <= alu_ovf;
            end
        end
    end

    assign res_push = pending;
    assign res_in   = res_q;

endmodule

`default_nettype wire

/* hw/alu_fifo.sv */
`default_nettype none

module alu_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  payload_t                   push_data,
    input  logic                       pop,
    output payload_t                   head,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(depth+1)-1:0] count
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_width = $clog2(depth + 1);

    payload_t             mem [depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic                 wr_en;
    logic                 rd_en;

    // Wrap at depth, which need not be a power of two
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        logic [ptr_width-1:0] nxt;
        if (ptr == ptr_width'(depth - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + ptr_width'(1);
        end
        return nxt;
    endfunction

    assign wr_en = push && !full;   // A push into a full buffer is dropped
    assign rd_en = pop && !empty;

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + cnt_width'(1);
                2'b01:   count <= count - cnt_width'(1);
                default: count <= count;  // Idle, or push and pop together
            endcase
        end
    end

    // Oldest entry, visible without a read cycle
    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == cnt_width'(depth));

endmodule

`default_nettype wire

/* hw/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    // Operand and result width
    localparam int data_width = 32;

    // Buffer depths
    localparam int cmd_depth = 4;
    localparam int res_depth = 4;

    // Occupancy of the result FIFO as seen by the ALU stage
    localparam int res_cnt_width = $clog2(res_depth + 1);

    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_not = 4'd5,  // Uses a only
        op_eq  = 4'd6,
        op_lt  = 4'd7,  // Signed compare
        op_gt  = 4'd8   // Signed compare
    } alu_op_e;

    // One ALU command as written by the producer
    typedef struct packed {
        alu_op_e               op;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
    } alu_cmd_t;

    // One result as read by the consumer
    typedef struct packed {
        logic [data_width-1:0] result;
        logic                  zero;      // Result is all zeros
        logic                  overflow;  // Signed overflow, ADD and SUB only
    } alu_res_t;

endpackage

`default_nettype wire
